// ==== soc_stimulus.txt ====
// Columns, all hex: op addr data sel expect. One operation per line
// op 1 wr, 2 rd+cmp, 3 wr random, 4 rd random (data merged by sel), 5 gpio_i, 6 idle,
// 7 wait irq_o (sel mask, data timeout), 8 gpio_o, 9 unmapped (data timeout), f end test, 0 stop
3 10000040 00000000 f 00000000
4 90000040 00000000 0 00000000
3 10000044 00000000 f 00000000
1 10000044 a5a5a5a5 5 00000000
4 90000044 a5a5a5a5 5 00000000
1 10000048 12345678 f 00000000
2 90000048 00000000 0 12345678
f 00000002 00000000 0 00000000
2 6000107c 00000000 0 4d310042
2 e000107c 00000000 0 4d310042
2 6000207c 00000000 0 00000000
1 60001004 00000003 f 00000000
8 00000000 00000000 0 00000003
2 60001004 00000000 0 00000003
5 00000000 00000055 0 00000000
6 00000000 00000004 0 00000000
2 60001000 00000000 0 00000055
f 00000003 00000000 0 00000000
1 6000100c 00000003 f 00000000
1 60001008 00000001 f 00000000
7 00000000 00000008 1 00000000
5 00000000 0000002a 0 00000000
7 00000000 00000010 1 00000001
2 6000100c 00000000 0 00000001
1 6000100c 00000001 f 00000000
7 00000000 00000008 1 00000000
f 00000004 00000000 0 00000000
1 60001008 00000002 f 00000000
1 60001014 00000010 f 00000000
1 60001010 00000001 f 00000000
7 00000000 00000040 2 00000002
2 60001010 00000000 0 00000000
2 6000100c 00000000 0 00000002
1 6000100c 00000002 f 00000000
7 00000000 00000008 2 00000000
f 00000005 00000000 0 00000000
9 20000000 00000014 0 00000000
2 e000107c 00000000 0 4d310042
2 10000048 00000000 0 12345678
f 00000006 00000000 0 00000000
0 00000000 00000000 0 00000000

// ==== src.f ====
soc_pkg.sv
reset_gen.sv
wb_decoder.sv
monitor_ram.sv
csr_bridge.sv
sysctl.sv
soc_top.sv
tb_soc_top.sv

// ==== tb_soc_top.sv ====
// Self-checking testbench for the system-control core
// Replays soc_stimulus.txt against the DUT, one operation per record,
// after checking the reset sequence. Run from the project root
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top
	import soc_pkg::*;
();

	localparam int          ACK_TIMEOUT   = 16;
	localparam int          RESET_TIMEOUT = 64;
	localparam int          MAX_OPS       = 64;
	localparam int          NUM_TESTS     = 6;
	localparam logic [31:0] TB_SYSTEM_ID  = 32'h4D31_0042;

	logic                      sys_clk;
	logic                      trigger_reset;
	wb_req_t                   wb_req;
	wb_rsp_t                   wb_rsp;
	logic [GPIO_IN_WIDTH-1:0]  gpio_in;
	logic [GPIO_OUT_WIDTH-1:0] gpio_out;
	logic [IRQ_WIDTH-1:0]      irq;
	logic                      flash_rst_n;
	logic                      periph_rst_n;

	// Five words per record in the order op addr data sel expect
	logic [31:0] stim [5*MAX_OPS];

	int          checks;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_err_base;
	int unsigned seed;

	soc_top #(
		.DEBOUNCE_CYCLES (20),
		.FLASH_RST_CYCLES(8),
		.MONITOR_WORDS   (64),
		.SYSTEM_ID       (TB_SYSTEM_ID)
	) UUT (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.wb_req_i      (wb_req),
		.wb_rsp_o      (wb_rsp),
		.gpio_i        (gpio_in),
		.gpio_o        (gpio_out),
		.irq_o         (irq),
		.flash_rst_n_o (flash_rst_n),
		.periph_rst_n_o(periph_rst_n)
	);

	// 100 ns clock
	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	function automatic string test_name(input int id);
		case (id)
			1:       return "reset order";
			2:       return "monitor ram";
			3:       return "csr path";
			4:       return "gpio interrupt";
			5:       return "timer";
			6:       return "unmapped region";
			default: return "unnamed";
		endcase
	endfunction

	// Monitor region answers in 1 cycle and CSR region in 3
	function automatic int expected_latency(input logic [31:0] addr);
		if (addr[30:28] == 3'b001)
			return 1;
		return 3;
	endfunction

	// Take data bytes where sel is set and base bytes elsewhere
	function automatic logic [31:0] merge_bytes(input logic [31:0] base, input logic [31:0] data,
		input logic [3:0] sel);
		logic [31:0] res;
		res = base;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[8*b +: 8] = data[8*b +: 8];
		end
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input int id);
		tests_run++;
		if (errors > test_err_base) begin
			tests_failed++;
			$display("Test %0d %s: FAILED with %0d errors", id, test_name(id), errors - test_err_base);
		end else begin
			$display("Test %0d %s: ok", id, test_name(id));
		end
		test_err_base = errors;
	endtask

	// ------------------------------
	// Wishbone master
	// ------------------------------
	// Strobe goes up on a rising edge and ack is sampled on falling edges
	// Strobe drops on the edge after ack or after the timeout
	task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] sel, input logic we, input int timeout,
		output logic [31:0] rdata, output logic acked, output int cycles);
		wb_req_t req;
		req     = '0;
		req.adr = addr;
		req.dat = data;
		req.sel = sel;
		req.we  = we;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		acked   = 1'b0;
		cycles  = 0;
		rdata   = '0;
		@(posedge sys_clk);
		wb_req <= req;
		while (!acked && cycles < timeout) begin
			@(negedge sys_clk);
			if (wb_rsp.ack) begin
				acked = 1'b1;
				rdata = wb_rsp.dat;
			end else begin
				cycles++;
			end
		end
		@(posedge sys_clk);
		wb_req <= '0;
	endtask

	task automatic check_ack(input logic [31:0] addr, input logic acked, input int cycles);
		checks++;
		assert (acked) else begin
			$display("Failure: no ack for access at %h within %0d cycles", addr, ACK_TIMEOUT);
			errors++;
		end
		if (acked)
			check_value("ack latency", 32'(cycles), 32'(expected_latency(addr)));
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] sel);
		logic [31:0] rdata;
		logic        acked;
		int          cycles;
		bus_access(addr, data, sel, 1'b1, ACK_TIMEOUT, rdata, acked, cycles);
		check_ack(addr, acked, cycles);
	endtask

	task automatic read_word(input logic [31:0] addr, output logic [31:0] rdata);
		logic acked;
		int   cycles;
		bus_access(addr, 32'd0, 4'hf, 1'b0, ACK_TIMEOUT, rdata, acked, cycles);
		check_ack(addr, acked, cycles);
	endtask

	// Poll irq_o under a mask until it matches or time runs out
	task automatic wait_for_irq(input logic [IRQ_WIDTH-1:0] mask, input logic [31:0] exp,
		input int timeout);
		int c;
		c = 0;
		@(negedge sys_clk);
		while (((irq & mask) !== exp[IRQ_WIDTH-1:0]) && c < timeout) begin
			@(negedge sys_clk);
			c++;
		end
		check_value("irq_o", 32'(irq & mask), exp);
	endtask

	// ------------------------------
	// Reset sequence
	// ------------------------------
	task automatic run_reset_sequence();
		int flash_at;
		int periph_at;
		int c;
		flash_at  = -1;
		periph_at = -1;
		repeat (7) @(posedge sys_clk);
		@(negedge sys_clk);
		check_value("flash_rst_n_o", 32'(flash_rst_n), 32'd0);
		check_value("periph_rst_n_o", 32'(periph_rst_n), 32'd0);
		check_value("irq_o", 32'(irq), 32'd0);
		check_value("gpio_o", 32'(gpio_out), 32'd0);
		@(posedge sys_clk);
		trigger_reset <= 1'b0;
		// Record the first cycle each reset output goes inactive
		for (c = 1; c <= RESET_TIMEOUT && periph_at < 0; c++) begin
			@(negedge sys_clk);
			if (flash_rst_n && flash_at < 0)
				flash_at = c;
			if (periph_rst_n)
				periph_at = c;
		end
		checks++;
		assert (periph_at > 0) else begin
			$display("Failure: periph_rst_n_o still low %0d cycles after reset release",
				RESET_TIMEOUT);
			errors++;
		end
		checks++;
		assert (flash_at > 0 && flash_at < periph_at) else begin
			$display("[ERROR] reset order: flash_rst_n_o rose at cycle %h, periph_rst_n_o at %h",
				flash_at, periph_at);
			errors++;
		end
		check_value("irq_o", 32'(irq), 32'd0);
		check_value("gpio_o", 32'(gpio_out), 32'd0);
		report_test(1);
	endtask

	// ------------------------------
	// Stimulus replay
	// ------------------------------
	task automatic run_stimulus();
		logic [31:0] op, addr, data, expv, rdata, rand_word;
		logic [3:0]  sel;
		logic        acked;
		int          cycles;
		rand_word = '0;
		for (int rec = 0; rec < MAX_OPS; rec++) begin
			op   = stim[5*rec];
			addr = stim[5*rec+1];
			data = stim[5*rec+2];
			sel  = stim[5*rec+3][3:0];
			expv = stim[5*rec+4];
			if (op == 32'h0)
				break;
			case (op)
				32'h1: write_word(addr, data, sel);
				32'h2: begin
					read_word(addr, rdata);
					check_value("wb_rsp_o.dat", rdata, expv);
				end
				32'h3: begin
					rand_word = $urandom();
					write_word(addr, rand_word, sel);
				end
				// Last random word with data bytes patched in by sel
				32'h4: begin
					read_word(addr, rdata);
					check_value("wb_rsp_o.dat", rdata, merge_bytes(rand_word, data, sel));
				end
				32'h5: begin
					@(posedge sys_clk);
					gpio_in <= data[GPIO_IN_WIDTH-1:0];
				end
				32'h6: repeat (data) @(posedge sys_clk);
				32'h7: wait_for_irq(sel[IRQ_WIDTH-1:0], expv, int'(data));
				32'h8: begin
					@(negedge sys_clk);
					check_value("gpio_o", 32'(gpio_out), expv);
				end
				// Unmapped access where the master gives up after data cycles
				32'h9: begin
					bus_access(addr, 32'd0, 4'hf, 1'b0, int'(data), rdata, acked, cycles);
					checks++;
					assert (!acked) else begin
						$display("Failure: access to unmapped address %h was acknowledged", addr);
						errors++;
					end
				end
				32'hf: report_test(int'(addr));
				default: begin
					checks++;
					assert (1'b0) else begin
						$display("Failure: unknown operation %h in stimulus record %0d", op, rec);
						errors++;
					end
				end
			endcase
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		trigger_reset = 1'b1;
		wb_req        = '0;
		gpio_in       = '0;
		checks        = 0;
		errors        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		test_err_base = 0;
		// Fixed seed for repeatable RAM data
		seed = $urandom(32'h108);
		for (int i = 0; i < 5*MAX_OPS; i++)
			stim[i] = '0;
		$readmemh("soc_stimulus.txt", stim);

		run_reset_sequence();
		run_stimulus();

		// A short or missing stimulus file ends the replay early
		checks++;
		assert (tests_run == NUM_TESTS) else begin
			$display("Failure: only %0d of %0d tests ran from the stimulus file",
				tests_run, NUM_TESTS);
			errors++;
		end

		$display("Tests run %0d, failed %0d; checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== soc_top.sv ====
// System-control core top level
// One external Wishbone master drives the decoder, which feeds
// the monitor RAM and the CSR bridge to the system controller
`timescale 1ns/1ps
`default_nettype none

module soc_top
	import soc_pkg::*;
#(
	parameter int          DEBOUNCE_CYCLES  = 1000,
	parameter int          FLASH_RST_CYCLES = 128,
	parameter int          MONITOR_WORDS    = 256,
	parameter logic [4:0]  SYSCTL_CSR_BANK  = 5'd1,
	parameter logic [31:0] SYSTEM_ID        = 32'h1004_4D31
) (
	input  wire                        sys_clk,
	input  wire                        trigger_reset,
	input  wb_req_t                    wb_req_i,
	output wb_rsp_t                    wb_rsp_o,
	input  wire  [GPIO_IN_WIDTH-1:0]   gpio_i,
	output logic [GPIO_OUT_WIDTH-1:0]  gpio_o,
	output logic [IRQ_WIDTH-1:0]       irq_o,
	output logic                       flash_rst_n_o,
	output logic                       periph_rst_n_o
);

	logic        sys_rst;
	wb_req_t     mon_req, csrbrg_req;
	wb_rsp_t     mon_rsp, csrbrg_rsp;
	csr_req_t    csr_cmd;
	logic [31:0] csr_rdata_sysctl;

	// ------------------------------
	// Reset
	// ------------------------------
	reset_gen #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.FLASH_RST_CYCLES(FLASH_RST_CYCLES)
	) u_reset_gen (
		.sys_clk      (sys_clk),
		.trigger_reset(trigger_reset),
		.sys_rst_o    (sys_rst),
		.flash_rst_n_o(flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	// ------------------------------
	// Bus
	// ------------------------------
	wb_decoder u_wb_decoder (
		.sys_clk(sys_clk), .sys_rst_i(sys_rst),
		.wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o),
		.mon_req_o(mon_req), .mon_rsp_i(mon_rsp),
		.csr_req_o(csrbrg_req), .csr_rsp_i(csrbrg_rsp)
	);

	monitor_ram #(.MONITOR_WORDS(MONITOR_WORDS)) u_monitor_ram (
		.sys_clk(sys_clk), .sys_rst_i(sys_rst),
		.wb_req_i(mon_req), .wb_rsp_o(mon_rsp)
	);

	// Further CSR banks OR their read words into csr_rdata_i
	csr_bridge u_csr_bridge (
		.sys_clk(sys_clk), .sys_rst_i(sys_rst),
		.wb_req_i(csrbrg_req), .wb_rsp_o(csrbrg_rsp),
		.csr_o(csr_cmd), .csr_rdata_i(csr_rdata_sysctl)
	);

	// System controller
	sysctl #(
		.SYSCTL_CSR_BANK(SYSCTL_CSR_BANK),
		.SYSTEM_ID      (SYSTEM_ID)
	) u_sysctl (
		.sys_clk(sys_clk), .sys_rst_i(sys_rst),
		.csr_i(csr_cmd), .csr_rdata_o(csr_rdata_sysctl),
		.gpio_i(gpio_i), .gpio_o(gpio_o), .irq_o(irq_o)
	);

endmodule

`default_nettype wire

// ==== sysctl.sv ====
// System controller CSR bank
// GPIO in/out with change interrupt, one timer, interrupt
// enable/pending registers and a read-only system id
`timescale 1ns/1ps
`default_nettype none

module sysctl
	import soc_pkg::*;
#(
	parameter logic [4:0]  SYSCTL_CSR_BANK = 5'd1,
	parameter logic [31:0] SYSTEM_ID       = 32'h0000_0000
) (
	input  wire                        sys_clk,
	input  wire                        sys_rst_i,
	input  csr_req_t                   csr_i,
	output logic [31:0]                csr_rdata_o,
	input  wire  [GPIO_IN_WIDTH-1:0]   gpio_i,
	output logic [GPIO_OUT_WIDTH-1:0]  gpio_o,
	output logic [IRQ_WIDTH-1:0]       irq_o
);

	logic                      bank_sel;
	logic [9:0]                reg_sel;
	logic                      wr;
	logic [GPIO_IN_WIDTH-1:0]  gpio_s1, gpio_s2, gpio_prev;
	logic [GPIO_OUT_WIDTH-1:0] gpio_out_q;
	logic [IRQ_WIDTH-1:0]      irq_en_q, irq_pend_q, irq_set, pend_clr;
	logic                      timer_en, timer_ar, timer_hit;
	logic [31:0]               timer_compare, timer_counter;
	logic [31:0]               rd_mux;

	assign bank_sel = (csr_i.adr[14:10] == SYSCTL_CSR_BANK);
	assign reg_sel  = csr_i.adr[9:0];
	assign wr       = bank_sel & csr_i.we;

	// ------------------------------
	// GPIO input sync
	// ------------------------------
	// Two-flop synchronizer plus a delayed copy for change detect
	always_ff @(posedge sys_clk) begin
		gpio_s1   <= gpio_i;
		gpio_s2   <= gpio_s1;
		gpio_prev <= gpio_s2;
	end

	assign timer_hit = timer_en & (timer_counter == timer_compare);

	// Interrupt sources and write-1-to-clear
	always_comb begin
		irq_set             = '0;
		irq_set[IRQ_GPIO]   = |(gpio_s2 ^ gpio_prev);
		irq_set[IRQ_TIMER0] = timer_hit;
		pend_clr = (wr && reg_sel == REG_IRQ_PEND) ? csr_i.dat[IRQ_WIDTH-1:0] : '0;
	end

	// ------------------------------
	// Registers and timer
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_q    <= '0;
			irq_en_q      <= '0;
			irq_pend_q    <= '0;
			timer_en      <= 1'b0;
			timer_ar      <= 1'b0;
			timer_compare <= '0;
			timer_counter <= '0;
		end else begin
			// Compare hit reloads or stops the timer
			if (timer_hit) begin
				if (timer_ar)
					timer_counter <= '0;
				else
					timer_en <= 1'b0;
			end else if (timer_en) begin
				timer_counter <= timer_counter + 32'd1;
			end
			// CSR writes win over the timer
			if (wr) begin
				case (reg_sel)
					REG_GPIO_OUT:      gpio_out_q    <= csr_i.dat[GPIO_OUT_WIDTH-1:0];
					REG_IRQ_EN:        irq_en_q      <= csr_i.dat[IRQ_WIDTH-1:0];
					REG_TIMER_CTRL: begin
						timer_en <= csr_i.dat[0];
						timer_ar <= csr_i.dat[1];
					end
					REG_TIMER_COMPARE: timer_compare <= csr_i.dat;
					REG_TIMER_COUNTER: timer_counter <= csr_i.dat;
					default: ;
				endcase
			end
			irq_pend_q <= (irq_pend_q & ~pend_clr) | irq_set;
		end
	end

	// Read mux
	always_comb begin
		case (reg_sel)
			REG_GPIO_IN:       rd_mux = 32'(gpio_s2);
			REG_GPIO_OUT:      rd_mux = 32'(gpio_out_q);
			REG_IRQ_EN:        rd_mux = 32'(irq_en_q);
			REG_IRQ_PEND:      rd_mux = 32'(irq_pend_q);
			REG_TIMER_CTRL:    rd_mux = {30'd0, timer_ar, timer_en};
			REG_TIMER_COMPARE: rd_mux = timer_compare;
			REG_TIMER_COUNTER: rd_mux = timer_counter;
			REG_SYSTEM_ID:     rd_mux = SYSTEM_ID;
			default:           rd_mux = '0;
		endcase
	end

	// Other banks read 0 so the bus can be ORed
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			csr_rdata_o <= '0;
		else
			csr_rdata_o <= bank_sel ? rd_mux : 32'd0;
	end

	assign gpio_o = gpio_out_q;
	assign irq_o  = irq_pend_q & irq_en_q;

endmodule

`default_nettype wire

// ==== csr_bridge.sv ====
// Wishbone to CSR bus bridge
// Each Wishbone access becomes one CSR cycle: issue, registered
// read, ack. Read data is the OR of all bank read words
`timescale 1ns/1ps
`default_nettype none

module csr_bridge
	import soc_pkg::*;
(
	input  wire         sys_clk,
	input  wire         sys_rst_i,
	input  wb_req_t     wb_req_i,
	output wb_rsp_t     wb_rsp_o,
	output csr_req_t    csr_o,
	input  wire  [31:0] csr_rdata_i
);

	csr_state_e  state;
	logic [31:0] rdat_q;

	// ------------------------------
	// Bridge FSM
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= CSR_IDLE;
			csr_o <= '0;
		end else begin
			case (state)
				CSR_IDLE: begin
					if (wb_req_i.cyc && wb_req_i.stb) begin
						// Word address, bank in bits 16..12
						csr_o.adr <= wb_req_i.adr[16:2];
						csr_o.we  <= wb_req_i.we;
						csr_o.dat <= wb_req_i.dat;
						state     <= CSR_ISSUE;
					end
				end
				CSR_ISSUE: begin
					// Bus back to address 0, no write
					csr_o <= '0;
					state <= CSR_READ;
				end
				CSR_READ:
					state <= CSR_ACK;
				default:
					state <= CSR_IDLE;
			endcase
		end
	end

	// Banks register their read word one cycle after issue
	always_ff @(posedge sys_clk) begin
		if (state == CSR_READ)
			rdat_q <= csr_rdata_i;
	end

	assign wb_rsp_o.dat = rdat_q;
	assign wb_rsp_o.ack = (state == CSR_ACK);

	a_ack_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		wb_rsp_o.ack |=> !wb_rsp_o.ack)
		else $error("CSR ack longer than one cycle");

endmodule

`default_nettype wire

// ==== monitor_ram.sv ====
// On-chip monitor RAM on the Wishbone bus
// Single port, word organised, byte writes through sel,
// acknowledges one cycle after the strobe
`timescale 1ns/1ps
`default_nettype none

module monitor_ram
	import soc_pkg::*;
#(
	parameter int MONITOR_WORDS = 256
) (
	input  wire     sys_clk,
	input  wire     sys_rst_i,
	input  wb_req_t wb_req_i,
	output wb_rsp_t wb_rsp_o
);

	localparam int AW = $clog2(MONITOR_WORDS);

	logic [31:0]   mem [MONITOR_WORDS];
	logic [AW-1:0] word_idx;
	logic [31:0]   rdat_q;
	logic          ack_q;
	logic          access;

	// Word index from byte address
	assign word_idx = wb_req_i.adr[AW+1:2];

	// No new access in the ack cycle, stb is still up there
	assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

	// ------------------------------
	// Storage
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (access && wb_req_i.we) begin
			for (int b = 0; b < 4; b++) begin
				if (wb_req_i.sel[b])
					mem[word_idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
			end
		end
		rdat_q <= mem[word_idx];
	end

	// Ack one cycle after strobe
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	assign wb_rsp_o.dat = rdat_q;
	assign wb_rsp_o.ack = ack_q;

endmodule

`default_nettype wire

// ==== wb_decoder.sv ====
// Wishbone address decoder for a single master
// Routes each access to the monitor RAM or the CSR bridge by region;
// bit 31 is ignored so every region has a shadow in the upper half
`timescale 1ns/1ps
`default_nettype none

module wb_decoder
	import soc_pkg::*;
(
	input  wire     sys_clk,
	input  wire     sys_rst_i,
	input  wb_req_t wb_req_i,
	output wb_rsp_t wb_rsp_o,
	// Monitor RAM port
	output wb_req_t mon_req_o,
	input  wb_rsp_t mon_rsp_i,
	// CSR bridge port
	output wb_req_t csr_req_o,
	input  wb_rsp_t csr_rsp_i
);

	region_e region;

	// ------------------------------
	// Region decode
	// ------------------------------
	// monitor  0x1000_0000 (shadow 0x9000_0000)
	// CSR      0x6000_0000 (shadow 0xe000_0000)
	always_comb begin
		region = REGION_NONE;
		if (wb_req_i.adr[30:28] == 3'b001)
			region = REGION_MONITOR;
		else if (wb_req_i.adr[30:29] == 2'b11)
			region = REGION_CSR;
	end

	// ------------------------------
	// Request fan-out
	// ------------------------------
	// Address and data go to both, only the selected slave sees cyc/stb
	always_comb begin
		mon_req_o     = wb_req_i;
		mon_req_o.cyc = wb_req_i.cyc & (region == REGION_MONITOR);
		mon_req_o.stb = wb_req_i.stb & (region == REGION_MONITOR);
		csr_req_o     = wb_req_i;
		csr_req_o.cyc = wb_req_i.cyc & (region == REGION_CSR);
		csr_req_o.stb = wb_req_i.stb & (region == REGION_CSR);
	end

	// Response mux, no slave behind REGION_NONE so no ack ever
	always_comb begin
		case (region)
			REGION_MONITOR: wb_rsp_o = mon_rsp_i;
			REGION_CSR:     wb_rsp_o = csr_rsp_i;
			default:        wb_rsp_o = '0;
		endcase
	end

	// ------------------------------
	// Checks
	// ------------------------------
	a_one_slave: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		!(mon_req_o.stb && csr_req_o.stb))
		else $error("both slave strobes high, adr=%h", wb_req_i.adr);

	// Slave acks must land inside the master's strobe
	a_ack_in_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb))
		else $error("ack outside an active cycle, adr=%h", wb_req_i.adr);

endmodule

`default_nettype wire

// ==== reset_gen.sv ====
// Reset sequencer
// Debounces trigger_reset into the system reset and releases
// the boot flash reset some cycles before the system reset
`timescale 1ns/1ps
`default_nettype none

module reset_gen #(
	parameter int DEBOUNCE_CYCLES  = 1000,
	parameter int FLASH_RST_CYCLES = 128
) (
	input  wire  sys_clk,
	input  wire  trigger_reset,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	localparam int DW = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int FW = $clog2(FLASH_RST_CYCLES + 1);

	logic [DW-1:0] rst_cnt;
	logic [FW-1:0] flash_cnt;

	// ------------------------------
	// System reset debounce
	// ------------------------------
	// Reload while trigger held, then count down
	// sys_rst drops on the edge the count reaches zero
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			rst_cnt   <= DW'(DEBOUNCE_CYCLES);
			sys_rst_o <= 1'b1;
		end else begin
			if (rst_cnt != '0)
				rst_cnt <= rst_cnt - DW'(1);
			sys_rst_o <= (rst_cnt > DW'(1));
		end
	end

	// ------------------------------
	// Flash reset release
	// ------------------------------
	// Flash needs time out of reset before the first fetch
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			flash_cnt     <= '0;
			flash_rst_n_o <= 1'b0;
		end else begin
			if (flash_cnt != FW'(FLASH_RST_CYCLES))
				flash_cnt <= flash_cnt + FW'(1);
			flash_rst_n_o <= (flash_cnt >= FW'(FLASH_RST_CYCLES - 1));
		end
	end

	// Flash must be out of reset by the time the system is
	a_flash_first: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		!sys_rst_o |-> flash_rst_n_o)
		else $error("flash reset released after system reset");

endmodule

`default_nettype wire

// ==== soc_pkg.sv ====
// Shared types and constants for the system-control core
// Wishbone and CSR bus structs, region and bridge state enums,
// sysctl register map and interrupt bit positions
`default_nettype none

package soc_pkg;

	// ------------------------------
	// Bus structs
	// ------------------------------

	// Wishbone request, master to slave
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
		logic        we;
		logic        cyc;
		logic        stb;
	} wb_req_t;

	// Wishbone response, slave to master
	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} wb_rsp_t;

	// CSR command, bank in adr[14:10], register in adr[9:0]
	typedef struct packed {
		logic [14:0] adr;
		logic        we;
		logic [31:0] dat;
	} csr_req_t;

	// ------------------------------
	// Decoding and bridge states
	// ------------------------------
	typedef enum logic [1:0] {REGION_NONE, REGION_MONITOR, REGION_CSR} region_e;

	typedef enum logic [1:0] {CSR_IDLE, CSR_ISSUE, CSR_READ, CSR_ACK} csr_state_e;

	// Sysctl register numbers within its bank
	parameter logic [9:0] REG_GPIO_IN       = 10'd0;
	parameter logic [9:0] REG_GPIO_OUT      = 10'd1;
	parameter logic [9:0] REG_IRQ_EN        = 10'd2;
	parameter logic [9:0] REG_IRQ_PEND      = 10'd3;
	parameter logic [9:0] REG_TIMER_CTRL    = 10'd4;
	parameter logic [9:0] REG_TIMER_COMPARE = 10'd5;
	parameter logic [9:0] REG_TIMER_COUNTER = 10'd6;
	parameter logic [9:0] REG_SYSTEM_ID     = 10'd31;

	// Interrupt vector layout
	parameter int IRQ_GPIO   = 0;
	parameter int IRQ_TIMER0 = 1;
	parameter int IRQ_WIDTH  = 2;

	// GPIO widths
	parameter int GPIO_IN_WIDTH  = 7;
	parameter int GPIO_OUT_WIDTH = 2;

endpackage

`default_nettype wire
